/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_dual_dcache -f dual_dcache.f
	./obj_dir/Vtb_dual_dcache | tee /dev/stderr | grep -F '** PASS **' > /dev/null

clean:
	rm -rf obj_dir

/* dcache_core.sv */
module dcache_core
   import dcache_pkg::*;
#(
   parameter int sets_p = 8
)
(
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  v_i,
   input  dcache_req_t           req_i,
   output logic                  ready_o,
   output logic                  v_o,
   output logic [data_width-1:0] data_o,
   output logic                  poison_o,
   mem_if.lane                   mem
);

   localparam int idx_width = $clog2(sets_p);
   localparam int tag_width = addr_width - idx_width;

   logic [tag_width-1:0]  tag_mem_r [sets_p];
   logic [data_width-1:0] data_mem_r [sets_p];
   logic [sets_p-1:0]     line_v_r;

   logic                  s1_v_r;
   dcache_req_t           s1_req_r;
   logic [idx_width-1:0]  s1_idx;
   logic                  s2_v_r;
   dcache_req_t           s2_req_r;
   logic                  s2_line_v_r;
   logic [tag_width-1:0]  s2_tag_r;
   logic [data_width-1:0] s2_data_r;
   logic [idx_width-1:0]  s2_idx;
   logic [tag_width-1:0]  s2_tag;

   logic                  is_store;
   logic                  hit;
   logic                  byp_hit;
   logic                  done;
   logic                  send;
   logic                  new_cmd;

   logic                  wr_en;
   logic [idx_width-1:0]  wr_idx;
   logic [tag_width-1:0]  wr_tag;
   logic [data_width-1:0] wr_data;
   logic                  fill_v;
   logic                  byp_fill;

   // Single command slot, pending until its response returns
   mem_cmd_t              cmd_r;
   logic                  cmd_uncached_r;
   logic                  pend_r;
   logic                  sent_r;

   // One-word buffer for uncached load data
   logic                  byp_v_r;
   logic [addr_width-1:0] byp_addr_r;
   logic [data_width-1:0] byp_data_r;

   assign s1_idx = s1_req_r.addr[idx_width-1:0];
   assign s2_idx = s2_req_r.addr[idx_width-1:0];
   assign s2_tag = s2_req_r.addr[addr_width-1:idx_width];

   assign is_store = (s2_req_r.op == op_store);
   assign hit = s2_line_v_r && (s2_tag_r == s2_tag);
   assign byp_hit = byp_v_r && (byp_addr_r == s2_req_r.addr);

   always_comb
   begin
      if (is_store)
      begin
         done = ~pend_r;
         send = ~pend_r;
      end
      else if (s2_req_r.uncached)
      begin
         done = byp_hit;
         send = ~byp_hit & ~pend_r;
      end
      else
      begin
         done = hit;
         send = ~hit & ~pend_r;
      end
   end

   assign v_o = s2_v_r & done;
   assign poison_o = s2_v_r & ~done;
   assign new_cmd = s2_v_r & send;
   assign data_o = is_store ? '0 : (s2_req_r.uncached ? byp_data_r : s2_data_r);
   assign ready_o = ~poison_o & ~pend_r;

   assign mem.cmd_v = pend_r & ~sent_r;
   assign mem.cmd = cmd_r;

   // Read data lands in the line or, for uncached, in the bypass word
   assign fill_v = mem.resp_v & ~cmd_r.write & ~cmd_uncached_r;
   assign byp_fill = mem.resp_v & ~cmd_r.write & cmd_uncached_r;

   assign wr_en = fill_v | (v_o & is_store & hit);
   assign wr_idx = fill_v ? cmd_r.addr[idx_width-1:0] : s2_idx;
   assign wr_tag = fill_v ? cmd_r.addr[addr_width-1:idx_width] : s2_tag;
   assign wr_data = fill_v ? mem.resp_data : s2_req_r.data;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         s1_v_r <= 1'b0;
         s2_v_r <= 1'b0;
      end
      else
      begin
         s1_v_r <= v_i;
         // Poison also squashes the younger access
         s2_v_r <= s1_v_r & ~poison_o;
      end
   end

   always_ff @(posedge clk_i)
   begin
      s1_req_r <= req_i;
      s2_req_r <= s1_req_r;
      // Forward a same-cycle line write
      if (wr_en && (wr_idx == s1_idx))
      begin
         s2_line_v_r <= 1'b1;
         s2_tag_r    <= wr_tag;
         s2_data_r   <= wr_data;
      end
      else
      begin
         s2_line_v_r <= line_v_r[s1_idx];
         s2_tag_r    <= tag_mem_r[s1_idx];
         s2_data_r   <= data_mem_r[s1_idx];
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (wr_en)
      begin
         tag_mem_r[wr_idx]  <= wr_tag;
         data_mem_r[wr_idx] <= wr_data;
      end
      if (new_cmd)
      begin
         cmd_r.write    <= is_store;
         cmd_r.addr     <= s2_req_r.addr;
         cmd_r.data     <= s2_req_r.data;
         cmd_uncached_r <= s2_req_r.uncached;
      end
      if (byp_fill)
      begin
         byp_addr_r <= cmd_r.addr;
         byp_data_r <= mem.resp_data;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         line_v_r <= '0;
         pend_r   <= 1'b0;
         sent_r   <= 1'b0;
         byp_v_r  <= 1'b0;
      end
      else
      begin
         if (wr_en)
         begin
            line_v_r[wr_idx] <= 1'b1;
         end
         if (new_cmd)
         begin
            pend_r <= 1'b1;
            sent_r <= 1'b0;
         end
         else
         begin
            if (mem.cmd_v && mem.cmd_ready)
            begin
               sent_r <= 1'b1;
            end
            if (mem.resp_v)
            begin
               pend_r <= 1'b0;
            end
         end
         if (byp_fill)
         begin
            byp_v_r <= 1'b1;
         end
         else if (v_o && (is_store || s2_req_r.uncached))
         begin
            byp_v_r <= 1'b0;
         end
      end
   end

endmodule

/* dcache_pkg.sv */
package dcache_pkg;

   // Word address and data word widths
   localparam int addr_width = 16;
   localparam int data_width = 32;

   typedef enum logic
   {
      op_load  = 1'b0,
      op_store = 1'b1
   } dcache_op_e;

   // One lane request as it sits in the replay queue
   typedef struct packed
   {
      dcache_op_e            op;
      logic                  uncached;
      logic [addr_width-1:0] addr;
      logic [data_width-1:0] data;
   } dcache_req_t;

   // Command toward memory, data only meaningful for a write
   typedef struct packed
   {
      logic                  write;
      logic [addr_width-1:0] addr;
      logic [data_width-1:0] data;
   } mem_cmd_t;

endpackage

/* dual_dcache.f */
dcache_pkg.sv
mem_if.sv
replay_fifo.sv
dcache_core.sv
mem_arbiter.sv
dual_dcache.sv
tb_mem_model.sv
tb_dual_dcache.sv

/* dual_dcache.sv */
module dual_dcache
   import dcache_pkg::*;
#(
   parameter int sets_p         = 8,
   parameter int replay_depth_p = 8
)
(
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  req_v_0_i,
   input  dcache_req_t           req_0_i,
   output logic                  ready_0_o,
   output logic                  v_0_o,
   output logic [data_width-1:0] data_0_o,
   input  logic                  req_v_1_i,
   input  dcache_req_t           req_1_i,
   output logic                  ready_1_o,
   output logic                  v_1_o,
   output logic [data_width-1:0] data_1_o,
   output logic                  mem_cmd_v_o,
   output mem_cmd_t              mem_cmd_o,
   input  logic                  mem_cmd_ready_i,
   input  logic                  mem_resp_v_i,
   input  logic [data_width-1:0] mem_resp_data_i
);

   logic        issue_v_0;
   logic        issue_v_1;
   dcache_req_t issue_req_0;
   dcache_req_t issue_req_1;
   logic        core_ready_0;
   logic        core_ready_1;
   logic        poison_0;
   logic        poison_1;

   mem_if mem0 ();
   mem_if mem1 ();

   // Lane 0
   replay_fifo #(.replay_depth_p(replay_depth_p)) i_fifo_0
   (
      .clk_i(clk_i), .rst_i(rst_i), .v_i(req_v_0_i), .req_i(req_0_i), .ready_o(ready_0_o),
      .issue_v_o(issue_v_0), .issue_req_o(issue_req_0), .core_ready_i(core_ready_0),
      .commit_i(v_0_o), .roll_i(poison_0)
   );

   dcache_core #(.sets_p(sets_p)) i_core_0
   (
      .clk_i(clk_i), .rst_i(rst_i), .v_i(issue_v_0), .req_i(issue_req_0),
      .ready_o(core_ready_0), .v_o(v_0_o), .data_o(data_0_o), .poison_o(poison_0), .mem(mem0)
   );

   // Lane 1
   replay_fifo #(.replay_depth_p(replay_depth_p)) i_fifo_1
   (
      .clk_i(clk_i), .rst_i(rst_i), .v_i(req_v_1_i), .req_i(req_1_i), .ready_o(ready_1_o),
      .issue_v_o(issue_v_1), .issue_req_o(issue_req_1), .core_ready_i(core_ready_1),
      .commit_i(v_1_o), .roll_i(poison_1)
   );

   dcache_core #(.sets_p(sets_p)) i_core_1
   (
      .clk_i(clk_i), .rst_i(rst_i), .v_i(issue_v_1), .req_i(issue_req_1),
      .ready_o(core_ready_1), .v_o(v_1_o), .data_o(data_1_o), .poison_o(poison_1), .mem(mem1)
   );

   mem_arbiter i_arbiter
   (
      .clk_i(clk_i), .rst_i(rst_i), .lane0(mem0), .lane1(mem1),
      .mem_cmd_v_o(mem_cmd_v_o), .mem_cmd_o(mem_cmd_o), .mem_cmd_ready_i(mem_cmd_ready_i),
      .mem_resp_v_i(mem_resp_v_i), .mem_resp_data_i(mem_resp_data_i)
   );

endmodule

/* mem_arbiter.sv */
module mem_arbiter
   import dcache_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  rst_i,
   mem_if.arbiter                lane0,
   mem_if.arbiter                lane1,
   output logic                  mem_cmd_v_o,
   output mem_cmd_t              mem_cmd_o,
   input  logic                  mem_cmd_ready_i,
   input  logic                  mem_resp_v_i,
   input  logic [data_width-1:0] mem_resp_data_i
);

   // owner_r is the last grant and also steers the response
   logic busy_r;
   logic locked_r;
   logic owner_r;
   logic pick;
   logic fire;

   always_comb
   begin
      if (locked_r)
      begin
         pick = owner_r;
      end
      else if (lane0.cmd_v && lane1.cmd_v)
      begin
         pick = ~owner_r;
      end
      else
      begin
         pick = lane1.cmd_v;
      end
   end

   assign mem_cmd_v_o = ~busy_r & (pick ? lane1.cmd_v : lane0.cmd_v);
   assign mem_cmd_o = pick ? lane1.cmd : lane0.cmd;
   assign fire = mem_cmd_v_o & mem_cmd_ready_i;

   assign lane0.cmd_ready = fire & ~pick;
   assign lane1.cmd_ready = fire & pick;

   assign lane0.resp_v = mem_resp_v_i & busy_r & ~owner_r;
   assign lane1.resp_v = mem_resp_v_i & busy_r & owner_r;
   assign lane0.resp_data = mem_resp_data_i;
   assign lane1.resp_data = mem_resp_data_i;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         busy_r   <= 1'b0;
         locked_r <= 1'b0;
         owner_r  <= 1'b0;
      end
      else
      begin
         if (mem_cmd_v_o)
         begin
            owner_r <= pick;
         end
         // Hold the grant while memory stalls
         locked_r <= mem_cmd_v_o & ~mem_cmd_ready_i;
         if (fire)
         begin
            busy_r <= 1'b1;
         end
         else if (mem_resp_v_i)
         begin
            busy_r <= 1'b0;
         end
      end
   end

endmodule

/* mem_if.sv */
interface mem_if
   import dcache_pkg::*;
();

   logic                  cmd_v;
   mem_cmd_t              cmd;
   logic                  cmd_ready;
   logic                  resp_v;
   logic [data_width-1:0] resp_data;

   modport lane
   (
      output cmd_v,
      output cmd,
      input  cmd_ready,
      input  resp_v,
      input  resp_data
   );

   modport arbiter
   (
      input  cmd_v,
      input  cmd,
      output cmd_ready,
      output resp_v,
      output resp_data
   );

endinterface

/* replay_fifo.sv */
module replay_fifo
   import dcache_pkg::*;
#(
   parameter int replay_depth_p = 8
)
(
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic        v_i,
   input  dcache_req_t req_i,
   output logic        ready_o,
   output logic        issue_v_o,
   output dcache_req_t issue_req_o,
   input  logic        core_ready_i,
   input  logic        commit_i,
   input  logic        roll_i
);

   localparam int ptr_width = $clog2(replay_depth_p);

   // Top pointer bit separates full from empty
   logic [ptr_width:0] wr_ptr_r;
   logic [ptr_width:0] iss_ptr_r;
   logic [ptr_width:0] cmt_ptr_r;
   logic [ptr_width:0] cmt_ptr_next;
   logic               full;
   logic               pending;
   logic               enq;
   dcache_req_t        mem_r [replay_depth_p];

   // Slots stay occupied until commit
   assign full = (wr_ptr_r[ptr_width] != cmt_ptr_r[ptr_width])
      && (wr_ptr_r[ptr_width-1:0] == cmt_ptr_r[ptr_width-1:0]);
   assign ready_o = ~full;
   assign enq = v_i & ~full;

   assign pending = (iss_ptr_r != wr_ptr_r);
   assign issue_v_o = pending & core_ready_i & ~roll_i;
   assign issue_req_o = mem_r[iss_ptr_r[ptr_width-1:0]];

   assign cmt_ptr_next = cmt_ptr_r + (ptr_width + 1)'(commit_i);

   always_ff @(posedge clk_i)
   begin
      if (enq)
      begin
         mem_r[wr_ptr_r[ptr_width-1:0]] <= req_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         wr_ptr_r  <= '0;
         iss_ptr_r <= '0;
         cmt_ptr_r <= '0;
      end
      else
      begin
         if (enq)
         begin
            wr_ptr_r <= wr_ptr_r + 1'b1;
         end
         cmt_ptr_r <= cmt_ptr_next;
         // Rollback replays from the oldest uncommitted entry
         if (roll_i)
         begin
            iss_ptr_r <= cmt_ptr_next;
         end
         else if (issue_v_o)
         begin
            iss_ptr_r <= iss_ptr_r + 1'b1;
         end
      end
   end

endmodule

/* tb_dual_dcache.sv */
module tb_dual_dcache
   import dcache_pkg::*;
();

   localparam int sets         = 8;
   localparam int replay_depth = 8;
   localparam int wait_limit   = 2000;

   typedef struct packed
   {
      dcache_req_t req;
      int          reads;
   } step_t;

   typedef struct packed
   {
      logic [addr_width-1:0] addr;
      logic [data_width-1:0] data;
      int                    reads;
   } expect_t;

   logic                  clk = 1'b0;
   logic                  rst;
   logic                  req_v_0;
   dcache_req_t           req_0;
   logic                  ready_0;
   logic                  v_0;
   logic [data_width-1:0] data_0;
   logic                  req_v_1;
   dcache_req_t           req_1;
   logic                  ready_1;
   logic                  v_1;
   logic [data_width-1:0] data_1;
   logic                  mem_cmd_v;
   mem_cmd_t              mem_cmd;
   logic                  mem_cmd_ready;
   logic                  mem_resp_v;
   logic [data_width-1:0] mem_resp_data;
   logic                  hold;

   logic [data_width-1:0] shadow [2**addr_width];
   int                    read_count [2**addr_width];
   step_t                 steps [2][$];
   expect_t               exp_q [2][$];
   int                    sent [2];
   int                    results [2];

   always #50 clk = ~clk;

   dual_dcache #(.sets_p(sets), .replay_depth_p(replay_depth)) i_dut
   (
      .clk_i(clk), .rst_i(rst),
      .req_v_0_i(req_v_0), .req_0_i(req_0), .ready_0_o(ready_0), .v_0_o(v_0), .data_0_o(data_0),
      .req_v_1_i(req_v_1), .req_1_i(req_1), .ready_1_o(ready_1), .v_1_o(v_1), .data_1_o(data_1),
      .mem_cmd_v_o(mem_cmd_v), .mem_cmd_o(mem_cmd), .mem_cmd_ready_i(mem_cmd_ready),
      .mem_resp_v_i(mem_resp_v), .mem_resp_data_i(mem_resp_data)
   );

   tb_mem_model #(.seed_p(32'hac49)) i_mem
   (
      .clk_i(clk), .rst_i(rst), .hold_i(hold), .cmd_v_i(mem_cmd_v), .cmd_i(mem_cmd),
      .cmd_ready_o(mem_cmd_ready), .resp_v_o(mem_resp_v), .resp_data_o(mem_resp_data)
   );

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("** FAIL **");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check_data(input logic [data_width-1:0] got, input logic [data_width-1:0] exp,
                             input string what);
      if (got !== exp)
      begin
         stop_run($sformatf("CHECK FAILED at time %0t: %s is %h, expected %h",
                            $time, what, got, exp));
      end
   endtask

   task automatic check_read_count(input logic [addr_width-1:0] addr, input int exp);
      if (read_count[addr] != exp)
      begin
         stop_run($sformatf("CHECK FAILED at time %0t: %0d memory reads of %h, expected %0d",
                            $time, read_count[addr], addr, exp));
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp)
      begin
         stop_run($sformatf("CHECK FAILED at time %0t: %s is %b, expected %b",
                            $time, what, got, exp));
      end
   endtask

   // Reads is the running count of memory reads of addr once this request is done
   task automatic add_step(input int lane, input dcache_op_e op, input logic uncached,
                           input logic [addr_width-1:0] addr, input logic [data_width-1:0] data,
                           input int reads);
      step_t step;
      step.req.op       = op;
      step.req.uncached = uncached;
      step.req.addr     = addr;
      step.req.data     = data;
      step.reads        = reads;
      steps[lane].push_back(step);
   endtask

   task automatic load_table();
      // Lane 0 directed sequence
      add_step(0, op_load,  1'b0, 16'h0011, 32'h0, 1);
      add_step(0, op_load,  1'b0, 16'h0011, 32'h0, 1);
      add_step(0, op_store, 1'b0, 16'h0022, 32'ha5a5_0001, 0);
      add_step(0, op_load,  1'b0, 16'h0022, 32'h0, 1);
      add_step(0, op_load,  1'b1, 16'h0022, 32'h0, 2);
      add_step(0, op_store, 1'b0, 16'h0011, 32'h5a5a_0002, 1);
      add_step(0, op_load,  1'b0, 16'h0011, 32'h0, 1);
      add_step(0, op_load,  1'b1, 16'h0033, 32'h0, 1);
      add_step(0, op_load,  1'b0, 16'h0033, 32'h0, 2);
      add_step(0, op_load,  1'b0, 16'h0033, 32'h0, 2);
      add_step(0, op_load,  1'b0, 16'h0019, 32'h0, 1);
      add_step(0, op_load,  1'b0, 16'h0011, 32'h0, 2);
      // Lane 0 part of the concurrent run
      add_step(0, op_load,  1'b0, 16'h0104, 32'h0, 1);
      add_step(0, op_load,  1'b0, 16'h0105, 32'h0, 1);
      add_step(0, op_store, 1'b0, 16'h0104, 32'h3333_0004, 1);
      add_step(0, op_load,  1'b0, 16'h0104, 32'h0, 1);
      add_step(0, op_load,  1'b1, 16'h0105, 32'h0, 2);
      add_step(0, op_load,  1'b0, 16'h0105, 32'h0, 2);
      add_step(0, op_load,  1'b0, 16'h0204, 32'h0, 1);
      add_step(0, op_load,  1'b0, 16'h0104, 32'h0, 2);
      // Lane 1 part of the concurrent run
      add_step(1, op_load,  1'b0, 16'h8001, 32'h0, 1);
      add_step(1, op_store, 1'b0, 16'h8001, 32'h1111_0001, 1);
      add_step(1, op_load,  1'b0, 16'h8001, 32'h0, 1);
      add_step(1, op_load,  1'b1, 16'h8002, 32'h0, 1);
      add_step(1, op_load,  1'b0, 16'h8002, 32'h0, 2);
      add_step(1, op_store, 1'b0, 16'h8003, 32'h2222_0003, 0);
      add_step(1, op_load,  1'b1, 16'h8003, 32'h0, 1);
      add_step(1, op_load,  1'b0, 16'h800b, 32'h0, 1);
      add_step(1, op_load,  1'b0, 16'h8009, 32'h0, 1);
      add_step(1, op_load,  1'b0, 16'h8001, 32'h0, 2);
      add_step(1, op_load,  1'b0, 16'h8002, 32'h0, 2);
      // One more than the queue holds, each a fresh miss
      for (int i = 0; i <= replay_depth; i++)
      begin
         add_step(0, op_load, 1'b0, 16'h0400 + 16'(i), 32'h0, 1);
      end
   endtask

   task automatic push_request(input int lane, input step_t step);
      int      cycles;
      expect_t exp;
      cycles = 0;
      @(negedge clk);
      if (lane == 0)
      begin
         req_v_0 = 1'b1;
         req_0   = step.req;
      end
      else
      begin
         req_v_1 = 1'b1;
         req_1   = step.req;
      end
      while ((lane == 0) ? !ready_0 : !ready_1)
      begin
         cycles++;
         if (cycles > wait_limit)
         begin
            stop_run($sformatf("Timeout: lane %0d request was never accepted", lane));
         end
         @(negedge clk);
      end
      @(posedge clk);
      // Accepted here, so expectations follow request order
      exp.addr  = step.req.addr;
      exp.reads = step.reads;
      if (step.req.op == op_store)
      begin
         exp.data = '0;
         shadow[step.req.addr] = step.req.data;
      end
      else
      begin
         exp.data = shadow[step.req.addr];
      end
      exp_q[lane].push_back(exp);
      sent[lane]++;
   endtask

   task automatic run_lane(input int lane, input int first, input int count);
      for (int i = first; i < first + count; i++)
      begin
         push_request(lane, steps[lane][i]);
      end
      @(negedge clk);
      if (lane == 0)
      begin
         req_v_0 = 1'b0;
      end
      else
      begin
         req_v_1 = 1'b0;
      end
   endtask

   task automatic wait_results();
      int cycles;
      cycles = 0;
      while (results[0] != sent[0] || results[1] != sent[1])
      begin
         @(negedge clk);
         cycles++;
         if (cycles > wait_limit)
         begin
            stop_run("Timeout: not every accepted request returned a result");
         end
      end
   endtask

   task automatic hold_until_full(input int target);
      int cycles;
      cycles = 0;
      while (sent[0] < target)
      begin
         @(negedge clk);
         cycles++;
         if (cycles > wait_limit)
         begin
            stop_run("Timeout: lane 0 queue never filled while memory was held");
         end
      end
      check_flag(ready_0, 1'b0, "ready_0 with a full replay queue");
      @(posedge clk);
      hold = 1'b0;
   endtask

   task automatic take_result(input int lane, input logic [data_width-1:0] data);
      expect_t exp;
      if (exp_q[lane].size() == 0)
      begin
         stop_run($sformatf("Lane %0d returned a result with no request outstanding", lane));
      end
      else
      begin
         exp = exp_q[lane].pop_front();
         check_data(data, exp.data, $sformatf("lane %0d data for %h", lane, exp.addr));
         check_read_count(exp.addr, exp.reads);
         results[lane]++;
      end
   endtask

   // Sampled mid-cycle, results first, then the read of the coming edge
   always @(negedge clk)
   begin
      #1;
      if (!rst)
      begin
         if (v_0)
         begin
            take_result(0, data_0);
         end
         if (v_1)
         begin
            take_result(1, data_1);
         end
         if (mem_cmd_v && mem_cmd_ready && !mem_cmd.write)
         begin
            read_count[mem_cmd.addr] += 1;
         end
      end
   end

   initial
   begin
      rst     = 1'b1;
      req_v_0 = 1'b0;
      req_0   = '0;
      req_v_1 = 1'b0;
      req_1   = '0;
      hold    = 1'b0;
      sent    = '{0, 0};
      results = '{0, 0};
      for (int a = 0; a < 2**addr_width; a++)
      begin
         shadow[a]     = a + 32'h1000_0000;
         read_count[a] = 0;
      end
      load_table();
      repeat (3) @(negedge clk);
      rst = 1'b0;
      @(posedge clk);
      check_flag(ready_0, 1'b1, "ready_0 after reset");
      check_flag(ready_1, 1'b1, "ready_1 after reset");
      check_flag(v_0, 1'b0, "v_0 after reset");
      check_flag(v_1, 1'b0, "v_1 after reset");
      check_flag(mem_cmd_v, 1'b0, "mem_cmd_v after reset");
      run_lane(0, 0, 12);
      wait_results();
      // Both lanes against random memory stalls
      fork
         run_lane(0, 12, 8);
         run_lane(1, 0, 11);
      join
      wait_results();
      @(posedge clk);
      hold = 1'b1;
      fork
         run_lane(0, 20, replay_depth + 1);
         hold_until_full(sent[0] + replay_depth);
      join
      wait_results();
      $display("** PASS **");
      $finish;
   end

endmodule

/* tb_mem_model.sv */
module tb_mem_model
   import dcache_pkg::*;
#(
   parameter int unsigned seed_p = 32'hac49
)
(
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  hold_i,
   input  logic                  cmd_v_i,
   input  mem_cmd_t              cmd_i,
   output logic                  cmd_ready_o,
   output logic                  resp_v_o,
   output logic [data_width-1:0] resp_data_o
);

   logic [data_width-1:0] words [2**addr_width];
   logic                  took;
   mem_cmd_t              cmd_q;
   logic                  busy;
   int                    countdown;

   initial
   begin
      void'($urandom(seed_p));
      for (int a = 0; a < 2**addr_width; a++)
      begin
         words[a] = a + 32'h1000_0000;
      end
      took        = 1'b0;
      busy        = 1'b0;
      countdown   = 0;
      cmd_ready_o = 1'b0;
      resp_v_o    = 1'b0;
      resp_data_o = '0;
      forever
      begin
         @(negedge clk_i);
         resp_v_o = 1'b0;
         if (rst_i)
         begin
            busy = 1'b0;
         end
         else if (took)
         begin
            busy      = 1'b1;
            countdown = $urandom_range(4, 1);
         end
         else if (busy)
         begin
            countdown--;
            if (countdown == 0)
            begin
               if (cmd_q.write)
               begin
                  words[cmd_q.addr] = cmd_q.data;
               end
               resp_data_o = words[cmd_q.addr];
               resp_v_o    = 1'b1;
               busy        = 1'b0;
            end
         end
         // Random acceptance stall, forced while hold_i is high
         cmd_ready_o = !rst_i && !busy && !hold_i && ($urandom_range(3, 0) != 0);
         // Command is stable here, handshake completes at the next rising edge
         took = cmd_v_i && cmd_ready_o && !rst_i;
         if (took)
         begin
            cmd_q = cmd_i;
         end
      end
   end

endmodule
